//--- compile.f
+incdir+.
exec_pkg.sv
rs_chooser.sv
alu.sv
rs.sv
exec_cluster.sv
tb_exec_cluster.sv

//--- tb_exec_model.svh
// testbench reference model with expected ALU results, per-tag state table and occupancy count

localparam int NTAGS    = 1 << ROB_BIT;
localparam int ST_FREE  = 0;
localparam int ST_LSB   = 1; // load result not yet sent
localparam int ST_ALU   = 2; // issued and awaiting its result
localparam int ST_DONE  = 3;

int          tag_st  [NTAGS];
logic [31:0] tag_val [NTAGS]; // value the tag will carry
int          in_station;      // issued but no broadcast seen
int          tag_ptr;

// result of one operation as the decoding table defines it
function automatic logic [31:0] ref_result(input logic [6:0] kind, input logic [2:0] f3,
                                           input logic alt, input logic [31:0] a,
                                           input logic [31:0] b);
    logic        [4:0]  sh;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sh = b[4:0];
    sa = a;
    sb = b;
    if (kind == BRANCH_TYPE) begin
        case (f3)
            3'b000:  return {31'b0, a == b};
            3'b001:  return {31'b0, a != b};
            3'b100:  return {31'b0, sa < sb};
            3'b101:  return {31'b0, sa >= sb};
            3'b110:  return {31'b0, a < b};
            default: return {31'b0, a >= b};
        endcase
    end
    case (f3)
        3'b000: begin
            if (kind == R_TYPE && alt) return a - b;
            return a + b;
        end
        3'b001: return a << sh;
        3'b010: return {31'b0, sa < sb};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (alt) return sa >>> sh;
            return a >> sh;
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic bit tag_available();
    for (int i = 0; i < NTAGS; i++) begin
        if (tag_st[i] == ST_FREE || tag_st[i] == ST_DONE) return 1'b1;
    end
    return 1'b0;
endfunction

// round robin so a tag is not reused right away
function automatic rob_tag_t alloc_tag();
    int t;
    for (int i = 0; i < NTAGS; i++) begin
        t = (tag_ptr + i) % NTAGS;
        if (tag_st[t] == ST_FREE || tag_st[t] == ST_DONE) begin
            tag_ptr = (t + 1) % NTAGS;
            return rob_tag_t'(t);
        end
    end
    return '0;
endfunction

//--- tb_exec_cluster.sv
// execution cluster testbench with clock, reset, xorshift stimulus, result checks and report
`timescale 1ns/1ps

module tb_exec_cluster import exec_pkg::*; ();

    localparam int RS_SIZE     = 8;
    localparam int CLK_PERIOD  = 40;
    localparam int TOTAL_INSTR = 40 + 8 + 8 + 6 + 8 + 10;
    localparam int MAX_CYCLES  = TOTAL_INSTR * 40 + 200;

    logic       clk_in;
    logic       arst_n;
    logic       rdy_in;
    logic       rob_clear_up;
    logic       issue;
    issue_pkt_t issue_pkt;
    cdb_t       lsb_cdb;
    cdb_t       alu_cdb;
    logic       rs_full;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          results_seen;
    int          cycles;
    int          err_mark;
    logic        last_rdy;
    rob_tag_t    last_tag;

    `include "tb_exec_model.svh"

    exec_cluster #(
        .RS_SIZE (RS_SIZE)
    ) i_dut (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .rdy_in       (rdy_in),
        .rob_clear_up (rob_clear_up),
        .issue        (issue),
        .issue_pkt    (issue_pkt),
        .lsb_cdb      (lsb_cdb),
        .alu_cdb      (alu_cdb),
        .rs_full      (rs_full)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic int rand_below(input int n);
        return int'(next_rand() % n);
    endfunction

    // output register only moves on edges where rdy_in was high
    always @(posedge clk_in) begin
        last_rdy <= rdy_in;
    end

    always @(negedge clk_in) begin
        if (arst_n && alu_cdb.valid && last_rdy) begin
            checks++;
            results_seen++;
            last_tag = alu_cdb.tag;
            assert (tag_st[alu_cdb.tag] == ST_ALU) else begin
                $display("unexpected broadcast of tag %0d, nothing outstanding for it",
                         alu_cdb.tag);
                errors++;
            end
            if (tag_st[alu_cdb.tag] == ST_ALU) begin
                assert (alu_cdb.value == tag_val[alu_cdb.tag]) else begin
                    $display("ERR alu_cdb.value tag %h: got %h, expected %h",
                             alu_cdb.tag, alu_cdb.value, tag_val[alu_cdb.tag]);
                    errors++;
                end
                tag_st[alu_cdb.tag] = ST_DONE;
                in_station--;
            end
        end else if (arst_n && alu_cdb.valid) begin
            assert (alu_cdb.tag == last_tag) else begin
                $display("ERR alu_cdb.tag during stall: got %h, expected %h",
                         alu_cdb.tag, last_tag);
                errors++;
            end
        end
    end

    always @(posedge clk_in) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d results still outstanding",
                     cycles, in_station);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // src < 0 means an operand with a plain value
    task automatic issue_instr(input int src1, input int src2, output rob_tag_t rd);
        issue_pkt_t  p;
        logic [31:0] a;
        logic [31:0] b;
        int          kind;
        int          s2;
        @(negedge clk_in);
        while (rs_full || in_station >= RS_SIZE || !tag_available()) @(negedge clk_in);
        rd   = alloc_tag();
        kind = rand_below(3);
        p    = '0;
        p.op_type = (kind == 0) ? R_TYPE : (kind == 1) ? ALGI_TYPE : BRANCH_TYPE;
        p.op  = 3'(rand_below(8));
        p.alt = 1'(rand_below(2));
        if (p.op_type == BRANCH_TYPE && p.op[2:1] == 2'b01) p.op[2] = 1'b1; // no 010/011
        s2 = (p.op_type == ALGI_TYPE) ? -1 : src2; // immediate
        a = next_rand();
        b = (rand_below(4) == 0) ? a : next_rand();
        p.v1 = a;
        p.v2 = b;
        if (src1 >= 0) begin
            a = tag_val[src1];
            p.v1 = a;
            if (tag_st[src1] != ST_DONE) begin
                p.v1   = next_rand();
                p.dep1 = 1'b1;
                p.tag1 = rob_tag_t'(src1);
            end
        end
        if (s2 >= 0) begin
            b = tag_val[s2];
            p.v2 = b;
            if (tag_st[s2] != ST_DONE) begin
                p.v2   = next_rand();
                p.dep2 = 1'b1;
                p.tag2 = rob_tag_t'(s2);
            end
        end
        p.rd_tag = rd;
        p.pc     = next_rand() & 32'hffff_fffc;
        tag_val[rd] = ref_result(p.op_type, p.op, p.alt, a, b);
        tag_st[rd]  = ST_ALU;
        in_station++;
        @(posedge clk_in);
        issue     <= 1'b1;
        issue_pkt <= p;
        @(posedge clk_in);
        issue     <= 1'b0;
    endtask

    task automatic new_load_tag(output rob_tag_t t);
        @(negedge clk_in);
        while (!tag_available()) @(negedge clk_in);
        t = alloc_tag();
        tag_st[t]  = ST_LSB;
        tag_val[t] = next_rand();
    endtask

    task automatic send_load(input rob_tag_t t);
        @(posedge clk_in);
        lsb_cdb <= '{valid: 1'b1, tag: t, value: tag_val[t]};
        @(posedge clk_in);
        lsb_cdb <= '0;
        tag_st[t] = ST_DONE;
    endtask

    task automatic drain();
        @(negedge clk_in);
        while (in_station != 0) @(negedge clk_in);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_in);
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        rob_tag_t lt [4];
        rob_tag_t t;
        rob_tag_t prev;
        int       seen;
        rng          = 32'd61370;
        errors       = 0;
        checks       = 0;
        results_seen = 0;
        cycles       = 0;
        err_mark     = 0;
        in_station   = 0;
        tag_ptr      = 0;
        last_tag     = '0;
        for (int i = 0; i < NTAGS; i++) tag_st[i] = ST_FREE;
        arst_n       = 1'b0;
        rdy_in       = 1'b1;
        rob_clear_up = 1'b0;
        issue        = 1'b0;
        issue_pkt    = '0;
        lsb_cdb      = '0;
        repeat (8) @(posedge clk_in);
        arst_n <= 1'b1;

        repeat (20) begin
            @(negedge clk_in);
            checks++;
            assert (!alu_cdb.valid && !rs_full) else begin
                $display("broadcast or full flag seen with nothing issued");
                errors++;
            end
        end
        report_test("reset idle");

        repeat (40) begin
            issue_instr(-1, -1, t);
            idle(rand_below(4));
        end
        drain();
        report_test("independent");

        for (int i = 0; i < 4; i++) new_load_tag(lt[i]);
        repeat (8) begin
            issue_instr(lt[rand_below(4)], (rand_below(2) != 0) ? lt[rand_below(4)] : -1, t);
        end
        seen = results_seen;
        idle(10);
        checks++;
        assert (results_seen == seen) else begin
            $display("result broadcast before its load operand was sent");
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            send_load(lt[i]);
            idle(rand_below(3));
        end
        drain();
        report_test("load wakeup");

        new_load_tag(lt[0]);
        prev = lt[0];
        repeat (8) begin
            issue_instr(prev, (rand_below(2) != 0) ? prev : -1, t);
            prev = t;
        end
        @(negedge clk_in);
        checks++;
        assert (rs_full) else begin
            $display("rs_full stayed low with eight waiting entries");
            errors++;
        end
        send_load(lt[0]);
        drain();
        @(negedge clk_in);
        checks++;
        assert (!rs_full) else begin
            $display("rs_full stayed high after the chain drained");
            errors++;
        end
        report_test("dependent chain");

        new_load_tag(lt[0]);
        repeat (6) issue_instr(lt[0], -1, t);
        send_load(lt[0]);
        @(posedge clk_in);
        rdy_in <= 1'b0; // woken entries wait behind the stall
        idle(3 + rand_below(16));
        rdy_in <= 1'b1;
        drain();
        report_test("stall");

        new_load_tag(lt[0]);
        repeat (RS_SIZE) issue_instr(lt[0], -1, t);
        send_load(lt[0]);
        rob_clear_up <= 1'b1; // first woken entry reaches the ALU on the flush edge
        @(posedge clk_in);
        rob_clear_up <= 1'b0;
        for (int i = 0; i < NTAGS; i++) begin
            if (tag_st[i] == ST_ALU || tag_st[i] == ST_LSB) tag_st[i] = ST_FREE;
        end
        in_station = 0;
        idle(10);
        @(negedge clk_in);
        checks++;
        assert (!rs_full) else begin
            $display("rs_full high after flush");
            errors++;
        end
        repeat (10) issue_instr(-1, -1, t);
        drain();
        report_test("flush");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- exec_cluster.sv
// integer execution cluster top with station, chooser and ALU, ALU result fed back
`timescale 1ns/1ps

module exec_cluster import exec_pkg::*; #(
    parameter int RS_SIZE = 8
) (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       rdy_in,
    input  logic       rob_clear_up,
    input  logic       issue,
    input  issue_pkt_t issue_pkt,
    input  cdb_t       lsb_cdb,
    output cdb_t       alu_cdb,
    output logic       rs_full
);

    alu_req_t alu_req;

    rs #(
        .RS_SIZE (RS_SIZE)
    ) i_rs (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .rdy_in       (rdy_in),
        .rob_clear_up (rob_clear_up),
        .issue        (issue),
        .issue_pkt    (issue_pkt),
        .lsb_cdb      (lsb_cdb),
        .alu_cdb      (alu_cdb), // self-forwarding wakeup
        .alu_req      (alu_req),
        .rs_full      (rs_full)
    );

    alu i_alu (
        .clk_in       (clk_in),
        .arst_n       (arst_n),
        .rdy_in       (rdy_in),
        .rob_clear_up (rob_clear_up),
        .alu_req      (alu_req),
        .alu_cdb      (alu_cdb)
    );

endmodule

//--- rs.sv
// reservation station with operand wakeup, issue write, dispatch request and flush
`timescale 1ns/1ps

module rs import exec_pkg::*; #(
    parameter int RS_SIZE = 8
) (
    input  logic       clk_in,
    input  logic       arst_n,
    input  logic       rdy_in,
    input  logic       rob_clear_up,
    input  logic       issue,
    input  issue_pkt_t issue_pkt,
    input  cdb_t       lsb_cdb,
    input  cdb_t       alu_cdb,
    output alu_req_t   alu_req,
    output logic       rs_full
);

    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    logic [RS_SIZE-1:0] busy_q;
    logic [RS_SIZE-1:0] prepared;
    issue_pkt_t         ent_q [RS_SIZE];

    logic [IDX_W-1:0]   issue_idx;
    logic [IDX_W-1:0]   exec_idx;
    logic               exec_ready;
    logic               wr_en;
    logic               disp;
    issue_pkt_t         sel;

    // capture a broadcast value for any pending operand with a matching tag
    function automatic issue_pkt_t snoop(input issue_pkt_t e, input cdb_t bc);
        issue_pkt_t r;
        r = e;
        if (bc.valid && e.dep1 && e.tag1 == bc.tag) begin
            r.v1   = bc.value;
            r.dep1 = 1'b0;
        end
        if (bc.valid && e.dep2 && e.tag2 == bc.tag) begin
            r.v2   = bc.value;
            r.dep2 = 1'b0;
        end
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            prepared[i] = busy_q[i] && !ent_q[i].dep1 && !ent_q[i].dep2;
        end
    end

    rs_chooser #(
        .RS_SIZE (RS_SIZE)
    ) i_chooser (
        .busy       (busy_q),
        .prepared   (prepared),
        .issue_idx  (issue_idx),
        .exec_idx   (exec_idx),
        .exec_ready (exec_ready),
        .full       (rs_full)
    );

    assign wr_en = issue && !rs_full;
    assign disp  = exec_ready && rdy_in;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else if (rob_clear_up) begin
            busy_q <= '0; // drop everything in flight
        end else if (rdy_in) begin
            if (exec_ready) begin
                busy_q[exec_idx] <= 1'b0;
            end
            if (wr_en) begin
                busy_q[issue_idx] <= 1'b1; // free slot, never the dispatched one
            end
        end
    end

    // new entry taken as issued, older ones listen to both buses
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (wr_en && issue_idx == IDX_W'(i)) begin
                    ent_q[i] <= issue_pkt;
                end else if (busy_q[i]) begin
                    ent_q[i] <= snoop(snoop(ent_q[i], lsb_cdb), alu_cdb);
                end
            end
        end
    end

    assign sel = ent_q[exec_idx];

    assign alu_req = '{
        valid:   disp,
        op_type: sel.op_type,
        op:      sel.op,
        alt:     sel.alt,
        a:       sel.v1,
        b:       sel.v2,
        rd_tag:  sel.rd_tag
    };

    // issuer has to watch rs_full
    a_no_issue_full: assert property (@(posedge clk_in) disable iff (!arst_n)
        issue |-> !rs_full);

    // chooser only picks live entries with both operands in hand
    a_exec_valid: assert property (@(posedge clk_in) disable iff (!arst_n)
        exec_ready |-> busy_q[exec_idx] && !ent_q[exec_idx].dep1 && !ent_q[exec_idx].dep2);

endmodule

//--- alu.sv
// one-stage integer ALU for arithmetic and branch compare, tagged result register
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  logic     clk_in,
    input  logic     arst_n,
    input  logic     rdy_in,
    input  logic     rob_clear_up,
    input  alu_req_t alu_req,
    output cdb_t     alu_cdb
);

    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  shamt;
    logic        sub;
    logic [31:0] arith;
    logic        taken;
    logic [31:0] result;
    logic        op_known;

    logic        valid_q;
    rob_tag_t    tag_q;
    logic [31:0] value_q;

    assign a     = alu_req.a;
    assign b     = alu_req.b;
    assign shamt = b[4:0];
    assign sub   = (alu_req.op_type == R_TYPE) && alu_req.alt; // no immediate subtract

    always_comb begin
        case (alu_req.op)
            F3_ADD:  arith = sub ? a - b : a + b;
            F3_SLL:  arith = a << shamt;
            F3_SLT:  arith = {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: arith = {31'b0, a < b};
            F3_XOR:  arith = a ^ b;
            F3_SR:   arith = alu_req.alt ? 32'($signed(a) >>> shamt) : a >> shamt;
            F3_OR:   arith = a | b;
            default: arith = a & b;
        endcase
    end

    always_comb begin
        case (alu_req.op)
            F3_BEQ:  taken = (a == b);
            F3_BNE:  taken = (a != b);
            F3_BLT:  taken = $signed(a) < $signed(b);
            F3_BGE:  taken = $signed(a) >= $signed(b);
            F3_BLTU: taken = a < b;
            F3_BGEU: taken = a >= b;
            default: taken = 1'b0; // 010/011 not a branch
        endcase
    end

    assign result = (alu_req.op_type == BRANCH_TYPE) ? {31'b0, taken} : arith;

    always_comb begin
        case (alu_req.op_type)
            R_TYPE, ALGI_TYPE: op_known = 1'b1;
            BRANCH_TYPE:       op_known = (alu_req.op != 3'b010) && (alu_req.op != 3'b011);
            default:           op_known = 1'b0;
        endcase
    end

    // flush wins over stall
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (rob_clear_up) begin
            valid_q <= 1'b0;
        end else if (rdy_in) begin
            valid_q <= alu_req.valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && alu_req.valid) begin
            tag_q   <= alu_req.rd_tag;
            value_q <= result;
        end
    end

    assign alu_cdb = '{valid: valid_q, tag: tag_q, value: value_q};

    // the station must only hand over instructions meant for this unit
    a_known_op: assert property (@(posedge clk_in) disable iff (!arst_n)
        alu_req.valid |-> op_known);

endmodule

//--- rs_chooser.sv
// priority pickers for free and ready station entries, plus full flag
`timescale 1ns/1ps

module rs_chooser #(
    parameter int RS_SIZE = 8
) (
    input  logic [RS_SIZE-1:0]                         busy,
    input  logic [RS_SIZE-1:0]                         prepared,
    output logic [((RS_SIZE > 1) ? $clog2(RS_SIZE) : 1)-1:0] issue_idx,
    output logic [((RS_SIZE > 1) ? $clog2(RS_SIZE) : 1)-1:0] exec_idx,
    output logic                                       exec_ready,
    output logic                                       full
);

    localparam int IDX_W = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    // lowest prepared entry wins dispatch
    always_comb begin
        exec_idx   = '0;
        exec_ready = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (prepared[i]) begin
                exec_idx   = IDX_W'(i);
                exec_ready = 1'b1;
            end
        end
    end

    // lowest free entry takes the next issue
    always_comb begin
        issue_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                issue_idx = IDX_W'(i);
            end
        end
    end

    assign full = &busy;

endmodule

//--- exec_pkg.sv
// shared opcode and funct3 constants, ROB tag width, issue, ALU request and broadcast structs
package exec_pkg;

    // ROB tag width, 16 tags in flight
    localparam int ROB_BIT = 4;

    // major opcodes handled by this cluster
    localparam logic [6:0] R_TYPE      = 7'b0110011;
    localparam logic [6:0] ALGI_TYPE   = 7'b0010011;
    localparam logic [6:0] BRANCH_TYPE = 7'b1100011;

    // funct3 for register and immediate arithmetic
    localparam logic [2:0] F3_ADD  = 3'b000; // sub when alt, R_TYPE only
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // sra when alt
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef logic [ROB_BIT-1:0] rob_tag_t;

    // one instruction as handed over by the issue stage
    typedef struct packed {
        logic [6:0]  op_type;
        logic [2:0]  op;      // funct3
        logic        alt;     // instruction bit 30
        logic [31:0] v1;
        logic [31:0] v2;      // immediate for ALGI_TYPE
        logic        dep1;    // v1 still waiting on tag1
        logic        dep2;    // v2 still waiting on tag2
        rob_tag_t    tag1;
        rob_tag_t    tag2;
        rob_tag_t    rd_tag;
        logic [31:0] pc;
    } issue_pkt_t;

    // operation leaving the station toward the ALU
    typedef struct packed {
        logic        valid;
        logic [6:0]  op_type;
        logic [2:0]  op;
        logic        alt;
        logic [31:0] a;
        logic [31:0] b;
        rob_tag_t    rd_tag;
    } alu_req_t;

    // result broadcast, LSB or ALU
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        logic [31:0] value;
    } cdb_t;

endpackage
